// File: source/video_pkg.sv
package video_pkg;

    // Pixel strobe divider
    localparam int PXL_DIV = 4;             // clk_sys cycles per pixel
    localparam int DBL_DIV = PXL_DIV / 2;   // Double rate strobe period
    localparam int DIV_W   = $clog2(PXL_DIV);

    // Line geometry
    localparam int H_ACTIVE_MAX = 64;
    localparam int ADDR_W       = 6;
    localparam int H_TOTAL      = 96;       // Pixel periods per input line
    localparam int HS_TICKS     = 8;        // Doubled hsync width in dbl ticks
    localparam int TICK_W       = $clog2(H_TOTAL);

    // Luma and chroma weights, scaled by 256
    localparam int Y_KR       = 77;
    localparam int Y_KG       = 150;
    localparam int Y_KB       = 29;
    localparam int PB_K       = 144;        // 0.564 of (B - Y)
    localparam int PR_K       = 183;        // 0.713 of (R - Y)
    localparam int CHROMA_MID = 32;

    typedef logic [3:0] game_colour_t;
    typedef logic [5:0] vga_colour_t;

    // Line buffer word
    typedef struct packed {
        game_colour_t r;
        game_colour_t g;
        game_colour_t b;
    } pixel_t;

    typedef logic [DIV_W-1:0]  div_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [ADDR_W:0]   len_t;       // Holds 0 to H_ACTIVE_MAX
    typedef logic [TICK_W-1:0] tick_t;

endpackage

// File: source/pixel_capture.sv
`timescale 1ns/10ps

module pixel_capture(
    input  logic                    clk_sys,
    input  logic                    rst,
    input  video_pkg::game_colour_t game_r,
    input  video_pkg::game_colour_t game_g,
    input  video_pkg::game_colour_t game_b,
    input  logic                    lhbl,
    input  logic                    lvbl,
    input  logic                    vs,
    output logic                    pxl_cen,
    output logic                    dbl_cen,
    output logic                    wr_en,
    output video_pkg::addr_t        wr_addr,
    output video_pkg::pixel_t       wr_data,
    output logic                    line_done,
    output video_pkg::len_t         line_len,
    output logic                    line_vs
);

video_pkg::div_t    div_cnt;
video_pkg::pixel_t  pix_s;      // Colour sampled on the last strobe
logic               lhbl_s;
logic               lvbl_s;
logic               vs_s;
logic               lhbl_l;     // Blanking one strobe before lhbl_s
logic               vs_line;    // vs held for the line being written
video_pkg::len_t    count;      // Pixels written so far on this line
video_pkg::len_t    idx;
logic               rise;
logic               fall;
logic               take;

always_ff @(posedge clk_sys) begin
    if (rst) begin
        div_cnt <= '0;
    end else if (div_cnt == video_pkg::div_t'(video_pkg::PXL_DIV - 1)) begin
        div_cnt <= '0;
    end else begin
        div_cnt <= div_cnt + 1'b1;
    end
end

assign pxl_cen = div_cnt == '0;
assign dbl_cen = (int'(div_cnt) % video_pkg::DBL_DIV) == 0;   // Every other one hits pxl_cen

// Edges seen on the sampled blanking, so everything acts one strobe late
assign rise = lhbl_s && !lhbl_l;
assign fall = !lhbl_s && lhbl_l;
assign idx  = rise ? '0 : count;
assign take = lhbl_s && lvbl_s && (idx < video_pkg::len_t'(video_pkg::H_ACTIVE_MAX));

always_ff @(posedge clk_sys) begin
    if (pxl_cen) begin
        pix_s <= {game_r, game_g, game_b};
    end
end

always_ff @(posedge clk_sys) begin
    if (rst) begin
        lhbl_s    <= 1'b0;
        lvbl_s    <= 1'b0;
        vs_s      <= 1'b1;
        lhbl_l    <= 1'b0;
        vs_line   <= 1'b1;
        count     <= '0;
        wr_en     <= 1'b0;
        line_done <= 1'b0;
        line_len  <= '0;
        line_vs   <= 1'b1;
    end else begin
        wr_en     <= 1'b0;
        line_done <= 1'b0;
        if (pxl_cen) begin
            lhbl_s <= lhbl;
            lvbl_s <= lvbl;
            vs_s   <= vs;
            lhbl_l <= lhbl_s;
            if (rise) begin
                count   <= '0;
                vs_line <= vs_s;
            end
            if (take) begin
                wr_en <= 1'b1;
                count <= idx + 1'b1;
            end
            if (fall) begin     // Last write has already landed
                line_done <= 1'b1;
                line_len  <= count;
                line_vs   <= vs_line;
            end
        end
    end
end

always_ff @(posedge clk_sys) begin
    if (pxl_cen && take) begin
        wr_addr <= video_pkg::addr_t'(idx);
        wr_data <= pix_s;
    end
end

endmodule

// File: source/line_buffer.sv
`timescale 1ns/10ps

module line_buffer(
    input  logic               clk_sys,
    input  logic               rst,
    input  logic               wr_en,
    input  video_pkg::addr_t   wr_addr,
    input  video_pkg::pixel_t  wr_data,
    input  logic               line_done,
    input  video_pkg::addr_t   rd_addr,
    output video_pkg::pixel_t  rd_data
);

localparam int DEPTH = 2 * video_pkg::H_ACTIVE_MAX;

video_pkg::pixel_t  mem [DEPTH];
logic               wr_bank;    // Bank taking the current input line
logic [video_pkg::ADDR_W:0] wr_ptr;
logic [video_pkg::ADDR_W:0] rd_ptr;

// Swap once the line is complete
always_ff @(posedge clk_sys) begin
    if (rst) begin
        wr_bank <= 1'b0;
    end else if (line_done) begin
        wr_bank <= !wr_bank;
    end
end

// Bank select in the top address bit
assign wr_ptr = {wr_bank, wr_addr};
assign rd_ptr = {!wr_bank, rd_addr};

always_ff @(posedge clk_sys) begin
    if (wr_en) begin
        mem[wr_ptr] <= wr_data;
    end
end

always_ff @(posedge clk_sys) begin
    rd_data <= mem[rd_ptr];     // One cycle read
end

endmodule

// File: source/scan_doubler.sv
`timescale 1ns/10ps

module scan_doubler(
    input  logic               clk_sys,
    input  logic               rst,
    input  logic               dbl_cen,
    input  logic               line_done,
    input  video_pkg::len_t    line_len,
    input  logic               line_vs,
    input  logic               en_mixing,
    output video_pkg::addr_t   rd_addr,
    input  video_pkg::pixel_t  rd_data,
    output video_pkg::pixel_t  dbl_pix,
    output logic               dbl_hs,
    output logic               dbl_vs
);

video_pkg::tick_t   tick;       // Position inside one copy
logic               copy;       // Second copy when high
logic               active;
video_pkg::len_t    len;
logic               vs_l;
video_pkg::pixel_t  prev;       // Pixel to the left, for mixing
video_pkg::pixel_t  mixed;
logic               last_tick;
logic               hs_tick;
logic               pix_tick;
logic               first_pix;
logic               mix_on;

// Truncated mean of two channels
function automatic video_pkg::game_colour_t avg(
    input video_pkg::game_colour_t a,
    input video_pkg::game_colour_t b
);
    logic [4:0] sum;
    sum = {1'b0, a} + {1'b0, b};
    return sum[4:1];
endfunction

assign last_tick = tick == video_pkg::tick_t'(video_pkg::H_TOTAL - 1);
assign hs_tick   = active && (tick < video_pkg::tick_t'(video_pkg::HS_TICKS));
assign pix_tick  = active && !hs_tick
                   && (int'(tick) < video_pkg::HS_TICKS + int'(len));
assign first_pix = tick == video_pkg::tick_t'(video_pkg::HS_TICKS);
assign mix_on    = en_mixing && copy && !first_pix;

// Address settles a cycle ahead of the dbl_cen that uses the data
assign rd_addr = video_pkg::addr_t'(tick - video_pkg::tick_t'(video_pkg::HS_TICKS));

always_comb begin
    mixed.r = avg(rd_data.r, prev.r);
    mixed.g = avg(rd_data.g, prev.g);
    mixed.b = avg(rd_data.b, prev.b);
end

// A new line always restarts playback, even mid copy
always_ff @(posedge clk_sys) begin
    if (rst) begin
        active <= 1'b0;
        copy   <= 1'b0;
        tick   <= '0;
        len    <= '0;
        vs_l   <= 1'b1;
    end else if (line_done) begin
        active <= 1'b1;
        copy   <= 1'b0;
        tick   <= '0;
        len    <= line_len;
        vs_l   <= line_vs;
    end else if (dbl_cen && active) begin
        if (last_tick) begin
            tick <= '0;
            copy <= 1'b1;
            if (copy) begin
                active <= 1'b0;     // Both copies shown
            end
        end else begin
            tick <= tick + 1'b1;
        end
    end
end

always_ff @(posedge clk_sys) begin
    if (rst) begin
        dbl_hs  <= 1'b1;
        dbl_vs  <= 1'b1;
        dbl_pix <= '0;
    end else if (dbl_cen) begin
        dbl_hs <= !hs_tick;
        dbl_vs <= !(active && !vs_l);
        if (pix_tick) begin
            dbl_pix <= mix_on ? mixed : rd_data;
        end else begin
            dbl_pix <= '0;      // Black outside the active run
        end
    end
end

always_ff @(posedge clk_sys) begin
    if (dbl_cen && pix_tick) begin
        prev <= rd_data;
    end
end

endmodule

// File: source/video_encoder.sv
`timescale 1ns/10ps

module video_encoder(
    input  logic                   clk_sys,
    input  logic                   rst,
    input  logic                   ypbpr,
    input  video_pkg::pixel_t      dbl_pix,
    input  logic                   dbl_hs,
    input  logic                   dbl_vs,
    output video_pkg::vga_colour_t vga_r,
    output video_pkg::vga_colour_t vga_g,
    output video_pkg::vga_colour_t vga_b,
    output logic                   vga_hs,
    output logic                   vga_vs
);

video_pkg::vga_colour_t r6;
video_pkg::vga_colour_t g6;
video_pkg::vga_colour_t b6;
video_pkg::vga_colour_t y;
video_pkg::vga_colour_t pb;
video_pkg::vga_colour_t pr;
logic                   csync;

function automatic video_pkg::vga_colour_t widen(input video_pkg::game_colour_t c);
    return {c, c[3:2]};
endfunction

function automatic video_pkg::vga_colour_t clamp6(input int v);
    if (v < 0) begin
        return '0;
    end else if (v > 63) begin
        return 6'd63;
    end
    return video_pkg::vga_colour_t'(v);
endfunction

assign r6 = widen(dbl_pix.r);
assign g6 = widen(dbl_pix.g);
assign b6 = widen(dbl_pix.b);

always_comb begin
    int y_sum;
    y_sum = video_pkg::Y_KR * int'(r6) + video_pkg::Y_KG * int'(g6)
          + video_pkg::Y_KB * int'(b6);
    y  = video_pkg::vga_colour_t'(y_sum >>> 8);     // Weights sum to 256, no overflow
    // Arithmetic shift floors negative differences
    pb = clamp6(video_pkg::CHROMA_MID + ((video_pkg::PB_K * (int'(b6) - int'(y))) >>> 8));
    pr = clamp6(video_pkg::CHROMA_MID + ((video_pkg::PR_K * (int'(r6) - int'(y))) >>> 8));
end

assign csync = !(dbl_hs ^ dbl_vs);  // Low when exactly one sync is low

always_ff @(posedge clk_sys) begin
    if (rst) begin
        vga_r  <= '0;
        vga_g  <= '0;
        vga_b  <= '0;
        vga_hs <= 1'b1;
        vga_vs <= 1'b1;
    end else if (ypbpr) begin
        vga_r  <= pr;
        vga_g  <= y;
        vga_b  <= pb;
        vga_hs <= csync;
        vga_vs <= 1'b1;     // Held high to select component input
    end else begin
        vga_r  <= r6;
        vga_g  <= g6;
        vga_b  <= b6;
        vga_hs <= dbl_hs;
        vga_vs <= dbl_vs;
    end
end

endmodule

// File: source/video_base.sv
`timescale 1ns/10ps

module video_base(
    input  logic                    clk_sys,
    input  logic                    rst,
    input  video_pkg::game_colour_t game_r,
    input  video_pkg::game_colour_t game_g,
    input  video_pkg::game_colour_t game_b,
    input  logic                    lhbl,
    input  logic                    lvbl,
    input  logic                    hs,         // Kept for core compatibility, lhbl sets timing
    input  logic                    vs,
    input  logic                    en_mixing,
    input  logic                    ypbpr,
    output logic                    pxl_cen,
    output video_pkg::vga_colour_t  vga_r,
    output video_pkg::vga_colour_t  vga_g,
    output video_pkg::vga_colour_t  vga_b,
    output logic                    vga_hs,
    output logic                    vga_vs
);

logic               dbl_cen;
logic               wr_en;
video_pkg::addr_t   wr_addr;
video_pkg::pixel_t  wr_data;
logic               line_done;
video_pkg::len_t    line_len;
logic               line_vs;
video_pkg::addr_t   rd_addr;
video_pkg::pixel_t  rd_data;
video_pkg::pixel_t  dbl_pix;
logic               dbl_hs;
logic               dbl_vs;

pixel_capture u_capture(
    .clk_sys   ( clk_sys   ),
    .rst       ( rst       ),
    .game_r    ( game_r    ),
    .game_g    ( game_g    ),
    .game_b    ( game_b    ),
    .lhbl      ( lhbl      ),
    .lvbl      ( lvbl      ),
    .vs        ( vs        ),
    .pxl_cen   ( pxl_cen   ),
    .dbl_cen   ( dbl_cen   ),
    .wr_en     ( wr_en     ),
    .wr_addr   ( wr_addr   ),
    .wr_data   ( wr_data   ),
    .line_done ( line_done ),
    .line_len  ( line_len  ),
    .line_vs   ( line_vs   )
);

line_buffer u_linebuf(
    .clk_sys   ( clk_sys   ),
    .rst       ( rst       ),
    .wr_en     ( wr_en     ),
    .wr_addr   ( wr_addr   ),
    .wr_data   ( wr_data   ),
    .line_done ( line_done ),
    .rd_addr   ( rd_addr   ),
    .rd_data   ( rd_data   )
);

scan_doubler u_doubler(
    .clk_sys   ( clk_sys   ),
    .rst       ( rst       ),
    .dbl_cen   ( dbl_cen   ),
    .line_done ( line_done ),
    .line_len  ( line_len  ),
    .line_vs   ( line_vs   ),
    .en_mixing ( en_mixing ),
    .rd_addr   ( rd_addr   ),
    .rd_data   ( rd_data   ),
    .dbl_pix   ( dbl_pix   ),
    .dbl_hs    ( dbl_hs    ),
    .dbl_vs    ( dbl_vs    )
);

video_encoder u_encoder(
    .clk_sys   ( clk_sys   ),
    .rst       ( rst       ),
    .ypbpr     ( ypbpr     ),
    .dbl_pix   ( dbl_pix   ),
    .dbl_hs    ( dbl_hs    ),
    .dbl_vs    ( dbl_vs    ),
    .vga_r     ( vga_r     ),
    .vga_g     ( vga_g     ),
    .vga_b     ( vga_b     ),
    .vga_hs    ( vga_hs    ),
    .vga_vs    ( vga_vs    )
);

endmodule

// File: bench/video_base_chk.sv
`timescale 1ns/10ps

module video_base_chk(
    input logic clk_sys,
    input logic rst,
    input logic pxl_cen,
    input logic ypbpr,
    input logic vga_hs,
    input logic vga_vs
);

int low_cnt;    // Consecutive cycles with vga_hs low

always @(posedge clk_sys) begin
    if (rst || vga_hs) begin
        low_cnt <= 0;
    end else begin
        low_cnt <= low_cnt + 1;
    end
end

strobe_single: assert property (@(posedge clk_sys) disable iff (rst)
    pxl_cen |=> !pxl_cen)
    else $error("pxl_cen high on two adjacent cycles");

hs_width: assert property (@(posedge clk_sys) disable iff (rst)
    ($rose(vga_hs) && !ypbpr) |-> low_cnt == 2 * video_pkg::HS_TICKS)
    else $error("vga_hs pulse width wrong");

vs_held: assert property (@(posedge clk_sys) disable iff (rst)
    (ypbpr && $past(ypbpr)) |-> vga_vs)
    else $error("vga_vs low in YPbPr mode");

endmodule

bind video_base video_base_chk i_chk(
    .clk_sys ( clk_sys ),
    .rst     ( rst     ),
    .pxl_cen ( pxl_cen ),
    .ypbpr   ( ypbpr   ),
    .vga_hs  ( vga_hs  ),
    .vga_vs  ( vga_vs  )
);

// File: bench/video_base_tb.sv
`timescale 1ns/10ps

module video_base_tb;

localparam int WAIT_LIMIT = 64;     // Cycles allowed per strobe wait

logic                    clk_sys = 1'b0;
logic                    rst = 1'b1;
video_pkg::game_colour_t game_r = '0;
video_pkg::game_colour_t game_g = '0;
video_pkg::game_colour_t game_b = '0;
logic                    lhbl = 1'b0;
logic                    lvbl = 1'b1;
logic                    hs = 1'b1;
logic                    vs = 1'b1;
logic                    en_mixing = 1'b0;
logic                    ypbpr = 1'b0;
logic                    pxl_cen;
video_pkg::vga_colour_t  vga_r;
video_pkg::vga_colour_t  vga_g;
video_pkg::vga_colour_t  vga_b;
logic                    vga_hs;
logic                    vga_vs;

video_pkg::pixel_t line_pix [video_pkg::H_ACTIVE_MAX];
logic [31:0]       rnd_state = 32'h471a_2e03;
logic [17:0]       pix_q [$];   // Collected {r, g, b} per output pixel
int                len_q [$];
logic              vs_q [$];    // vga_vs at the start of each output line
int                cur_len;
logic              started;
logic              hs_prev = 1'b1;
logic              pd1 = 1'b0;
logic              pd2 = 1'b0;

video_base i_dut(.*);

always #20 clk_sys = !clk_sys;

function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

function automatic video_pkg::vga_colour_t widen6(input video_pkg::game_colour_t c);
    return {c, c[3:2]};     // Top bits repeated
endfunction

function automatic video_pkg::vga_colour_t limit6(input int v);
    return (v < 0) ? 6'd0 : (v > 63) ? 6'd63 : video_pkg::vga_colour_t'(v);
endfunction

// Expected output triple for one doubled pixel in the current mode
function automatic logic [17:0] encode(input video_pkg::pixel_t p, input logic yuv);
    int r;
    int g;
    int b;
    int y;
    r = int'(widen6(p.r));
    g = int'(widen6(p.g));
    b = int'(widen6(p.b));
    if (!yuv) begin
        return {6'(r), 6'(g), 6'(b)};
    end
    y = (video_pkg::Y_KR * r + video_pkg::Y_KG * g + video_pkg::Y_KB * b) >>> 8;
    return {limit6(video_pkg::CHROMA_MID + ((video_pkg::PR_K * (r - y)) >>> 8)), 6'(y),
            limit6(video_pkg::CHROMA_MID + ((video_pkg::PB_K * (b - y)) >>> 8))};
endfunction

function automatic video_pkg::pixel_t average(input video_pkg::pixel_t a,
                                               input video_pkg::pixel_t b);
    video_pkg::pixel_t m;
    m.r = 4'((int'(a.r) + int'(b.r)) / 2);
    m.g = 4'((int'(a.g) + int'(b.g)) / 2);
    m.b = 4'((int'(a.b) + int'(b.b)) / 2);
    return m;
endfunction

task automatic abort(input string line);
    $display("%s", line);
    $display("test failed");
    $fatal(1);
endtask

task automatic check_colour(input video_pkg::vga_colour_t expected,
                            input video_pkg::vga_colour_t actual, input string what);
    if (expected !== actual) begin
        abort($sformatf("error at %0t: %s is %0d, expected %0d", $time, what, actual, expected));
    end
endtask

task automatic check_sync(input bit expected, input bit actual, input string what);
    if (expected !== actual) begin
        abort($sformatf("error at %0t: %s is %0b, expected %0b", $time, what, actual, expected));
    end
endtask

task automatic wait_pxl();
    int cnt;
    cnt = 0;
    @(posedge clk_sys);
    while (!pxl_cen) begin
        if (cnt >= WAIT_LIMIT) begin
            abort("Timed out waiting for the pixel strobe");
        end
        cnt++;
        @(posedge clk_sys);
    end
endtask

task automatic idle(input int periods);
    repeat (periods) begin
        wait_pxl();
        lhbl <= 1'b0;
    end
endtask

// One input line of H_TOTAL pixel periods, first n with lhbl high
task automatic drive_line(input int n, input logic vs_lvl);
    for (int i = 0; i < video_pkg::H_TOTAL; i++) begin
        wait_pxl();
        lhbl   <= i < n;
        vs     <= vs_lvl;
        game_r <= (i < n) ? line_pix[i].r : 4'h0;
        game_g <= (i < n) ? line_pix[i].g : 4'h0;
        game_b <= (i < n) ? line_pix[i].b : 4'h0;
    end
endtask

// Monitor samples the middle of each two-cycle output pixel
always @(posedge clk_sys) begin
    pd1 <= pxl_cen;
    pd2 <= pd1;
    if (!rst && (pxl_cen || pd2)) begin
        if (hs_prev && !vga_hs) begin
            if (started) begin
                len_q.push_back(cur_len);
            end
            vs_q.push_back(vga_vs);
            started = 1'b1;
            cur_len = 0;
        end else if (vga_hs && started && {vga_r, vga_g, vga_b} != encode('0, ypbpr)) begin
            pix_q.push_back({vga_r, vga_g, vga_b});
            cur_len++;
        end
        hs_prev = vga_hs;
    end
end

task automatic begin_capture();
    pix_q.delete();
    len_q.delete();
    vs_q.delete();
    started = 1'b0;
    cur_len = 0;
endtask

task automatic end_capture(input int lines);
    idle(video_pkg::H_TOTAL);
    if (started) begin
        len_q.push_back(cur_len);
    end
    if (len_q.size() != lines) begin
        abort($sformatf("error at %0t: %0d output lines, expected %0d",
                        $time, len_q.size(), lines));
    end
endtask

task automatic check_line(input int k, input int n, input bit mix);
    int off;
    logic [17:0] e;
    video_pkg::pixel_t p;
    off = 0;
    for (int j = 0; j < k; j++) begin
        off += len_q[j];
    end
    if (len_q[k] != n) begin
        abort($sformatf("error at %0t: line %0d has %0d pixels, expected %0d",
                        $time, k, len_q[k], n));
    end
    for (int i = 0; i < n; i++) begin
        p = (mix && i > 0) ? average(line_pix[i], line_pix[i-1]) : line_pix[i];
        e = encode(p, ypbpr);
        check_colour(e[17:12], pix_q[off+i][17:12], $sformatf("red of pixel %0d", i));
        check_colour(e[11:6], pix_q[off+i][11:6], $sformatf("green of pixel %0d", i));
        check_colour(e[5:0], pix_q[off+i][5:0], $sformatf("blue of pixel %0d", i));
    end
endtask

task automatic fill_random(input int n);
    for (int i = 0; i < n; i++) begin
        rnd_state = xorshift(rnd_state);
        line_pix[i] = video_pkg::pixel_t'(rnd_state[11:0]);
        if (line_pix[i] == '0) begin
            line_pix[i] = 12'h001;      // Never black
        end
    end
endtask

task automatic test_reset_state();
    wait_pxl();
    check_colour(6'd0, vga_r, "red after reset");
    check_colour(6'd0, vga_g, "green after reset");
    check_colour(6'd0, vga_b, "blue after reset");
    check_sync(1'b1, vga_hs, "vga_hs after reset");
    check_sync(1'b1, vga_vs, "vga_vs after reset");
endtask

task automatic test_doubling(input bit mix);
    for (int i = 0; i < 20; i++) begin
        line_pix[i] = video_pkg::pixel_t'(i * 37 + (mix ? 11 : 5));
    end
    en_mixing <= mix;
    idle(4);
    begin_capture();
    drive_line(20, 1'b1);
    end_capture(2);
    check_line(0, 20, 1'b0);
    check_line(1, 20, mix);
    en_mixing <= 1'b0;
endtask

task automatic test_vsync();
    logic pattern [4] = '{1'b1, 1'b0, 1'b0, 1'b1};
    fill_random(10);
    begin_capture();
    foreach (pattern[i]) begin
        drive_line(10, pattern[i]);
    end
    end_capture(8);
    for (int i = 0; i < 8; i++) begin
        check_sync(pattern[i/2], vs_q[i], $sformatf("vga_vs of output line %0d", i));
    end
    vs <= 1'b1;
endtask

task automatic test_ypbpr();
    fill_random(16);
    ypbpr <= 1'b1;
    idle(4);
    begin_capture();
    drive_line(16, 1'b1);
    end_capture(2);    // Two composite sync pulses seen
    check_line(0, 16, 1'b0);
    check_line(1, 16, 1'b0);
    check_sync(1'b1, vs_q[0], "vga_vs in YPbPr mode");
    check_sync(1'b1, vs_q[1], "vga_vs in YPbPr mode");
    // A vsync line goes into composite sync only
    drive_line(16, 1'b0);
    vs <= 1'b1;
    for (int i = 0; i < video_pkg::H_TOTAL; i++) begin
        wait_pxl();
        check_sync(1'b1, vga_vs, "vga_vs on a vsync line in YPbPr mode");
    end
    ypbpr <= 1'b0;
endtask

task automatic test_random_lines();
    int n;
    for (int k = 0; k < 8; k++) begin
        rnd_state = xorshift(rnd_state);
        n = int'(rnd_state % video_pkg::H_ACTIVE_MAX) + 1;
        fill_random(n);
        begin_capture();
        drive_line(n, 1'b1);
        end_capture(2);
        check_line(0, n, 1'b0);
        check_line(1, n, 1'b0);
    end
endtask

initial begin
    repeat (5) @(posedge clk_sys);
    rst <= 1'b0;
    test_reset_state();
    test_doubling(1'b0);
    test_doubling(1'b1);
    test_vsync();
    test_ypbpr();
    test_random_lines();
    $display("test passed");
    $finish;
end

endmodule

// File: filelist.f
source/video_pkg.sv
source/pixel_capture.sv
source/line_buffer.sv
source/scan_doubler.sv
source/video_encoder.sv
source/video_base.sv
bench/video_base_chk.sv
bench/video_base_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= video_base_tb
DUT_TOP   ?= video_base
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^test passed$$"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(DUT_TOP) \
		source/video_pkg.sv source/pixel_capture.sv source/line_buffer.sv \
		source/scan_doubler.sv source/video_encoder.sv source/video_base.sv

clean:
	rm -rf $(OBJ_DIR)
